/* Makefile */
# Verilator build for the instruction cache testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_pri_icache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_pri_icache.sv */
////////////////////////////////////////
// Instruction cache testbench
// Clock, reset, memory model, row table
// Compare tasks and timeouts
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_pri_icache;

   // One row of stimulus and its expectation
   typedef struct packed {
      logic [31:0] addr;
      logic        bypass;
      logic        flush_before;
      logic        exp_hit;
   } row_t;

   localparam int NUM_ROWS       = 16;
   localparam int GNT_TIMEOUT    = 20;
   localparam int RVALID_TIMEOUT = 60;
   localparam int MODE_TIMEOUT   = 10;

   logic                        clk;
   logic                        rst_i;
   logic                        fetch_req_i;
   icache_cfg_pkg::fetch_addr_t fetch_addr_i;
   logic                        fetch_gnt_o;
   logic                        fetch_rvalid_o;
   icache_bus_pkg::line_t       fetch_rdata_o;
   logic                        refill_req_o;
   logic                        refill_gnt_i;
   icache_bus_pkg::refill_req_t refill_addr_o;
   logic                        refill_r_valid_i;
   icache_bus_pkg::line_t       refill_r_data_i;
   logic                        bypass_icache_i;
   logic                        cache_is_bypassed_o;
   logic                        flush_icache_i;
   logic                        cache_is_flushed_o;

   // Memory model state, seen by the stimulus
   icache_bus_pkg::refill_req_t last_refill;
   int                          refill_count;
   integer                      seed = 32'hd2ea;

   // Expected flushed flag, tracked from the rows
   logic                        model_flushed;
   row_t                        rows [NUM_ROWS];

   pri_icache u_pri_icache (
      .clk                 ( clk                 ),
      .rst_i               ( rst_i               ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_req_o        ( refill_req_o        ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .refill_addr_o       ( refill_addr_o       ),
      .refill_r_valid_i    ( refill_r_valid_i    ),
      .refill_r_data_i     ( refill_r_data_i     ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .flush_icache_i      ( flush_icache_i      ),
      .cache_is_flushed_o  ( cache_is_flushed_o  )
   );

   // 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////
   // Reference data and compare tasks
   ////////////////////////////////////////

   // Memory content: word i of line A is (A + i) xor 5a5a_0000
   function automatic icache_bus_pkg::line_t expected_line(input logic [31:0] line_addr);
      icache_bus_pkg::line_t line;
      for (int w = 0; w < 4; w++)
         line[w*32 +: 32] = (line_addr + 32'(w)) ^ 32'h5a5a_0000;
      return line;
   endfunction

   task automatic check_line(input icache_bus_pkg::line_t got,
                             input icache_bus_pkg::line_t exp, input string what);
      if (got !== exp)
      begin
         $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
         $display("TESTS FAILED");
         $fatal(1, "line mismatch");
      end
   endtask

   task automatic check_addr(input icache_bus_pkg::refill_req_t got,
                             input icache_bus_pkg::refill_req_t exp, input string what);
      if (got !== exp)
      begin
         $display("FAIL %0t ns: %s got %h expected %h", $time, what, got.addr, exp.addr);
         $display("TESTS FAILED");
         $fatal(1, "address mismatch");
      end
   endtask

   // Hit means no refill request between acceptance and rvalid
   task automatic check_hit(input logic refilled, input logic exp_hit, input string what);
      if (!refilled !== exp_hit)
      begin
         $display("FAIL %0t ns: %s hit %b expected %b", $time, what, !refilled, exp_hit);
         $display("TESTS FAILED");
         $fatal(1, "hit mismatch");
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("FAIL %0t ns: %s got %b expected %b", $time, what, got, exp);
         $display("TESTS FAILED");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic timeout_abort(input string what);
      $display("Timeout: gave up waiting for %s at %0t ns", what, $time);
      $display("TESTS FAILED");
      $fatal(1, "wait timed out");
   endtask

   ////////////////////////////////////////
   // Memory model
   ////////////////////////////////////////

   // Grant after 0 to 3 cycles, answer 1 to 4 cycles later
   initial
   begin : memory_model
      int                          gnt_delay;
      int                          resp_delay;
      icache_bus_pkg::refill_req_t held_addr;
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      refill_count     = 0;
      last_refill      = '0;
      forever
      begin
         @(negedge clk);
         if (refill_req_o === 1'b1)
         begin
            held_addr = refill_addr_o;
            gnt_delay = $random(seed) & 3;
            // Request must stay steady while not granted
            for (int i = 0; i < gnt_delay; i++)
            begin
               @(negedge clk);
               check_flag(refill_req_o, 1'b1, "refill_req_o under back-pressure");
               check_addr(refill_addr_o, held_addr, "refill_addr_o under back-pressure");
            end
            @(posedge clk);
            refill_gnt_i <= 1'b1;
            @(posedge clk);
            refill_gnt_i <= 1'b0;
            last_refill  = held_addr;
            refill_count = refill_count + 1;
            resp_delay   = 1 + ($random(seed) & 3);
            repeat (resp_delay) @(posedge clk);
            refill_r_valid_i <= 1'b1;
            refill_r_data_i  <= expected_line(held_addr.addr);
            @(posedge clk);
            refill_r_valid_i <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Address, bypass, flush before, expected hit
   task automatic load_rows();
      rows[0]  = '{32'h0000_0104, 1'b0, 1'b0, 1'b0};  // First fetch misses
      rows[1]  = '{32'h0000_0108, 1'b0, 1'b0, 1'b1};  // Same line hits
      rows[2]  = '{32'h0000_1020, 1'b0, 1'b0, 1'b0};  // Set 2, first way
      rows[3]  = '{32'h0000_2020, 1'b0, 1'b0, 1'b0};  // Set 2, second way
      rows[4]  = '{32'h0000_3020, 1'b0, 1'b0, 1'b0};  // Evicts 1020
      rows[5]  = '{32'h0000_1020, 1'b0, 1'b0, 1'b0};  // Evicted line misses
      rows[6]  = '{32'h0000_3020, 1'b0, 1'b0, 1'b1};  // Newest still hits
      rows[7]  = '{32'h0000_0100, 1'b1, 1'b0, 1'b0};  // Bypass refetches cached line
      rows[8]  = '{32'h0000_0240, 1'b1, 1'b0, 1'b0};  // Fetched only in bypass
      rows[9]  = '{32'h0000_0240, 1'b0, 1'b0, 1'b0};  // Not cached by bypass
      rows[10] = '{32'h0000_010c, 1'b0, 1'b0, 1'b1};  // Bypass left line in place
      rows[11] = '{32'h0000_0100, 1'b0, 1'b1, 1'b0};  // Flush, then miss
      rows[12] = '{32'h0000_3020, 1'b0, 1'b0, 1'b0};
      rows[13] = '{32'h0000_0240, 1'b0, 1'b0, 1'b0};
      rows[14] = '{32'h0000_1028, 1'b0, 1'b0, 1'b0};
      rows[15] = '{32'h0000_0104, 1'b0, 1'b0, 1'b1};  // Refilled after flush
   endtask

   // Bypass level and optional flush pulse before a fetch
   task automatic apply_mode(input row_t row);
      int cycles;
      @(posedge clk);
      bypass_icache_i <= row.bypass;
      if (row.flush_before)
         flush_icache_i <= 1'b1;
      @(posedge clk);
      flush_icache_i <= 1'b0;
      cycles = 0;
      @(negedge clk);
      while (cache_is_bypassed_o !== row.bypass)
      begin
         cycles++;
         if (cycles > MODE_TIMEOUT)
            timeout_abort("cache_is_bypassed_o to follow bypass_icache_i");
         @(negedge clk);
      end
      if (row.flush_before)
      begin
         check_flag(cache_is_flushed_o, 1'b1, "cache_is_flushed_o after flush");
         model_flushed = 1'b1;
      end
   endtask

   task automatic run_fetch(input row_t row);
      int                          cycles;
      int                          first_req;
      int                          count_before;
      logic                        refilled;
      logic                        done;
      icache_bus_pkg::line_t       got_line;
      icache_bus_pkg::refill_req_t exp_req;
      exp_req.addr = row.addr & 32'hffff_fff0;
      @(posedge clk);
      fetch_req_i  <= 1'b1;
      fetch_addr_i <= row.addr;
      // Wait for the grant
      cycles = 0;
      @(negedge clk);
      while (fetch_gnt_o !== 1'b1)
      begin
         cycles++;
         if (cycles > GNT_TIMEOUT)
            timeout_abort("fetch_gnt_o");
         @(negedge clk);
      end
      count_before = refill_count;
      // Accepting edge
      @(posedge clk);
      fetch_req_i <= 1'b0;
      // Watch for a refill until the line comes back
      refilled  = 1'b0;
      first_req = 0;
      done      = 1'b0;
      cycles    = 0;
      got_line  = '0;
      while (!done)
      begin
         @(negedge clk);
         cycles++;
         if ((refill_req_o === 1'b1) && !refilled)
         begin
            refilled  = 1'b1;
            first_req = cycles;
         end
         if (fetch_rvalid_o === 1'b1)
         begin
            done     = 1'b1;
            got_line = fetch_rdata_o;
         end
         else if (cycles >= RVALID_TIMEOUT)
            timeout_abort("refill request or fetch_rvalid_o");
      end
      check_hit(refilled, row.exp_hit, "lookup result");
      check_line(got_line, expected_line(exp_req.addr), "fetch_rdata_o");
      if (row.exp_hit)
         check_flag(cycles == 2, 1'b1, "hit rvalid 2 cycles after acceptance");
      else
      begin
         check_flag(first_req >= 3, 1'b1, "refill_req_o no earlier than 3 cycles");
         check_flag(refill_count == count_before + 1, 1'b1, "one refill per miss");
         check_addr(last_refill, exp_req, "refill_addr_o");
         // A cached refill clears the flushed state
         if (!row.bypass)
            model_flushed = 1'b0;
      end
      check_flag(cache_is_flushed_o, model_flushed, "cache_is_flushed_o");
      check_flag(cache_is_bypassed_o, row.bypass, "cache_is_bypassed_o");
   endtask

   initial
   begin : stimulus
      row_t row;
      rst_i           = 1'b1;
      fetch_req_i     = 1'b0;
      fetch_addr_i    = '0;
      bypass_icache_i = 1'b0;
      flush_icache_i  = 1'b0;
      model_flushed   = 1'b1;
      load_rows();
      repeat (2) @(posedge clk);
      rst_i <= 1'b0;
      // State right after reset
      @(negedge clk);
      check_flag(fetch_gnt_o, 1'b1, "fetch_gnt_o after reset");
      check_flag(cache_is_flushed_o, 1'b1, "cache_is_flushed_o after reset");
      check_flag(cache_is_bypassed_o, 1'b0, "cache_is_bypassed_o after reset");
      check_flag(fetch_rvalid_o, 1'b0, "fetch_rvalid_o after reset");
      check_flag(refill_req_o, 1'b0, "refill_req_o after reset");
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         row = rows[i];
         apply_mode(row);
         run_fetch(row);
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/icache_bus_pkg.sv */
////////////////////////////////////////
// Instruction cache bus payloads
// Fetch line and refill request types
////////////////////////////////////////

`default_nettype none

package icache_bus_pkg;

   // One cache line, also the fetch word
   typedef logic [icache_cfg_pkg::FETCH_DATA_WIDTH-1:0] line_t;

   // Refill request toward the next memory level
   // Address is always line aligned
   typedef struct packed {
      logic [icache_cfg_pkg::FETCH_ADDR_WIDTH-1:0] addr;
   } refill_req_t;

endpackage

`default_nettype wire

/* rtl/icache_cfg_pkg.sv */
////////////////////////////////////////
// Instruction cache geometry constants
// Fetch address split and tag entry types
////////////////////////////////////////

`default_nettype none

package icache_cfg_pkg;

   ////////////////////////////////////////
   // Geometry
   ////////////////////////////////////////

   // Core fetch address and line width
   localparam int FETCH_ADDR_WIDTH = 32;
   localparam int FETCH_DATA_WIDTH = 128;

   // Two ways, 512 bytes in total
   localparam int NB_WAYS    = 2;
   localparam int CACHE_SIZE = 512;

   // One fetch word per line
   localparam int NB_SETS      = CACHE_SIZE / (NB_WAYS * (FETCH_DATA_WIDTH / 8));
   localparam int OFFSET_WIDTH = $clog2(FETCH_DATA_WIDTH / 8);
   localparam int SET_ID_WIDTH = $clog2(NB_SETS);
   // Full width tag, no reduced option
   localparam int TAG_WIDTH    = FETCH_ADDR_WIDTH - SET_ID_WIDTH - OFFSET_WIDTH;

   ////////////////////////////////////////
   // Types
   ////////////////////////////////////////

   // Fetch address fields, MSB first
   typedef struct packed {
      logic [TAG_WIDTH-1:0]    tag;
      logic [SET_ID_WIDTH-1:0] set_id;
      logic [OFFSET_WIDTH-1:0] offset;
   } fetch_addr_t;

   // One entry of the tag store
   typedef struct packed {
      logic                 valid;
      logic [TAG_WIDTH-1:0] tag;
   } tag_entry_t;

   // One-hot way select
   typedef logic [NB_WAYS-1:0] way_sel_t;

endpackage

`default_nettype wire

/* rtl/icache_ctrl.sv */
////////////////////////////////////////
// Instruction cache controller
// Lookup and refill FSM, hit and victim
// Bypass and whole-cache flush control
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
   input  logic                                                    clk,
   input  logic                                                    rst_i,
   // Core fetch port
   input  logic                                                    fetch_req_i,
   input  icache_cfg_pkg::fetch_addr_t                             fetch_addr_i,
   output logic                                                    fetch_gnt_o,
   output logic                                                    fetch_rvalid_o,
   output icache_bus_pkg::line_t                                   fetch_rdata_o,
   // Mode control
   input  logic                                                    bypass_icache_i,
   output logic                                                    cache_is_bypassed_o,
   input  logic                                                    flush_icache_i,
   output logic                                                    cache_is_flushed_o,
   // Tag and data stores
   output logic                                                    tag_rd_en_o,
   output logic                                                    data_rd_en_o,
   output logic [icache_cfg_pkg::SET_ID_WIDTH-1:0]                 set_id_o,
   output logic                                                    wr_en_o,
   output icache_cfg_pkg::way_sel_t                                wr_way_o,
   output logic [icache_cfg_pkg::TAG_WIDTH-1:0]                    wr_tag_o,
   output icache_bus_pkg::line_t                                   wr_line_o,
   output logic                                                    flush_o,
   input  icache_cfg_pkg::tag_entry_t [icache_cfg_pkg::NB_WAYS-1:0] tag_entry_i,
   input  icache_bus_pkg::line_t [icache_cfg_pkg::NB_WAYS-1:0]      line_i,
   // Refill buffers
   output logic                                                    refill_push_o,
   output icache_bus_pkg::refill_req_t                             refill_addr_o,
   input  logic                                                    refill_ready_i,
   input  logic                                                    resp_valid_i,
   input  icache_bus_pkg::line_t                                   resp_line_i
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_REQUEST,
      ST_WAIT_RESP,
      ST_RESPOND
   } state_e;

   state_e                      state_q;
   state_e                      state_d;
   icache_cfg_pkg::fetch_addr_t addr_q;
   icache_bus_pkg::line_t       line_q;
   icache_bus_pkg::line_t       hit_line;
   icache_cfg_pkg::way_sel_t    hit_way;
   icache_cfg_pkg::way_sel_t    victim_q;
   logic                        accept;
   logic                        hit;
   logic                        bypass_q;
   logic                        flushed_q;
   logic                        flush_pend_q;

   ////////////////////////////////////////
   // Core side handshake
   ////////////////////////////////////////

   // Flush runs in idle, no fetch accepted in that cycle
   assign flush_o     = (state_q == ST_IDLE) && (flush_icache_i || flush_pend_q);
   assign fetch_gnt_o = (state_q == ST_IDLE) && !flush_o;
   assign accept      = fetch_req_i && fetch_gnt_o;

   // Tag read on every fetch, data read skipped when bypassing
   assign tag_rd_en_o  = accept;
   assign data_rd_en_o = accept && !bypass_icache_i;

   // Set index from the live address in idle, held address otherwise
   assign set_id_o = (state_q == ST_IDLE) ? fetch_addr_i.set_id : addr_q.set_id;

   assign fetch_rvalid_o      = (state_q == ST_RESPOND);
   assign fetch_rdata_o       = line_q;
   assign cache_is_bypassed_o = bypass_q;
   assign cache_is_flushed_o  = flushed_q;

   ////////////////////////////////////////
   // Hit detection
   ////////////////////////////////////////

   // Compare registered entries against the held tag
   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < icache_cfg_pkg::NB_WAYS; w++)
      begin
         hit_way[w] = tag_entry_i[w].valid && (tag_entry_i[w].tag == addr_q.tag);
         if (hit_way[w])
            hit_line = line_i[w];
      end
   end

   // Bypass forces a miss
   assign hit = (|hit_way) && !bypass_q;

   ////////////////////////////////////////
   // Refill side
   ////////////////////////////////////////

   // Push held until the request buffer has room
   assign refill_push_o      = (state_q == ST_REQUEST);
   assign refill_addr_o.addr = {addr_q.tag, addr_q.set_id,
                                {icache_cfg_pkg::OFFSET_WIDTH{1'b0}}};

   // Returned line goes to the victim way unless bypassed
   assign wr_en_o   = (state_q == ST_WAIT_RESP) && resp_valid_i && !bypass_q;
   assign wr_way_o  = victim_q;
   assign wr_tag_o  = addr_q.tag;
   assign wr_line_o = resp_line_i;

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:
            if (accept)
               state_d = ST_LOOKUP;
         // Store outputs valid here
         ST_LOOKUP:
            state_d = hit ? ST_RESPOND : ST_REQUEST;
         ST_REQUEST:
            if (refill_ready_i)
               state_d = ST_WAIT_RESP;
         ST_WAIT_RESP:
            if (resp_valid_i)
               state_d = ST_RESPOND;
         ST_RESPOND:
            state_d = ST_IDLE;
         default:
            state_d = ST_IDLE;
      endcase
   end

   // Control state
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         state_q      <= ST_IDLE;
         bypass_q     <= 1'b0;
         flushed_q    <= 1'b1;
         flush_pend_q <= 1'b0;
         victim_q     <= icache_cfg_pkg::way_sel_t'(1);
      end
      else
      begin
         state_q <= state_d;
         // Bypass mode only changes between fetches
         if (state_q == ST_IDLE)
            bypass_q <= bypass_icache_i;
         // Flush seen while busy waits for idle
         if (flush_o)
            flush_pend_q <= 1'b0;
         else if (flush_icache_i)
            flush_pend_q <= 1'b1;
         // Flushed until the next refill write
         if (flush_o)
            flushed_q <= 1'b1;
         else if (wr_en_o)
            flushed_q <= 1'b0;
         // Round robin victim, rotates on each refill write
         if (wr_en_o)
            victim_q <= {victim_q[icache_cfg_pkg::NB_WAYS-2:0],
                         victim_q[icache_cfg_pkg::NB_WAYS-1]};
      end
   end

   // Held address and returned line
   always_ff @(posedge clk)
   begin
      if (accept)
         addr_q <= fetch_addr_i;
      if ((state_q == ST_LOOKUP) && hit)
         line_q <= hit_line;
      else if ((state_q == ST_WAIT_RESP) && resp_valid_i)
         line_q <= resp_line_i;
   end

endmodule

`default_nettype wire

/* rtl/icache_data_ram.sv */
////////////////////////////////////////
// Instruction cache data store
// One line per set and way
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_data_ram (
   input  logic                                               clk,
   input  logic                                               rd_en_i,
   input  logic [icache_cfg_pkg::SET_ID_WIDTH-1:0]            set_id_i,
   input  logic                                               wr_en_i,
   input  icache_cfg_pkg::way_sel_t                           wr_way_i,
   input  icache_bus_pkg::line_t                              wr_line_i,
   output icache_bus_pkg::line_t [icache_cfg_pkg::NB_WAYS-1:0] rd_line_o
);

   // Line array
   icache_bus_pkg::line_t line_mem [icache_cfg_pkg::NB_WAYS][icache_cfg_pkg::NB_SETS];

   // Refill write into the victim way
   always_ff @(posedge clk)
   begin
      if (wr_en_i)
      begin
         for (int w = 0; w < icache_cfg_pkg::NB_WAYS; w++)
         begin
            if (wr_way_i[w])
               line_mem[w][set_id_i] <= wr_line_i;
         end
      end
   end

   // Parallel read of every way into the output register
   // Controller picks the hitting way a cycle later
   always_ff @(posedge clk)
   begin
      if (rd_en_i)
      begin
         for (int w = 0; w < icache_cfg_pkg::NB_WAYS; w++)
         begin
            rd_line_o[w] <= line_mem[w][set_id_i];
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/icache_fifo.sv */
////////////////////////////////////////
// Two-entry FIFO, payload set by type
// Refill request and response buffer
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_fifo #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_i,
   input  logic     push_i,
   input  payload_t data_i,
   output logic     ready_o,
   output logic     valid_o,
   output payload_t data_o,
   input  logic     pop_i
);

   // Storage, no reset on payload
   payload_t mem_q [2];

   logic       wr_ptr_q;
   logic       rd_ptr_q;
   logic [1:0] count_q;
   logic       do_push;
   logic       do_pop;

   // Full at two entries, push refused then
   assign ready_o = (count_q != 2'd2);
   assign valid_o = (count_q != 2'd0);
   assign data_o  = mem_q[rd_ptr_q];

   // Only handshaked transfers move pointers
   assign do_push = push_i && ready_o;
   assign do_pop  = pop_i && valid_o;

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= ~wr_ptr_q;
         if (do_pop)
            rd_ptr_q <= ~rd_ptr_q;
         // Count unchanged on push and pop together
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 2'd1;
            2'b01:   count_q <= count_q - 2'd1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Entry visible at data_o the cycle after the push
   always_ff @(posedge clk)
   begin
      if (do_push)
         mem_q[wr_ptr_q] <= data_i;
   end

endmodule

`default_nettype wire

/* rtl/icache_tag_ram.sv */
////////////////////////////////////////
// Instruction cache tag store
// Tag and valid bit per set and way
// Registered read, refill write, flush
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_tag_ram (
   input  logic                                                    clk,
   input  logic                                                    rst_i,
   input  logic                                                    rd_en_i,
   input  logic [icache_cfg_pkg::SET_ID_WIDTH-1:0]                 set_id_i,
   input  logic                                                    wr_en_i,
   input  icache_cfg_pkg::way_sel_t                                wr_way_i,
   input  logic [icache_cfg_pkg::TAG_WIDTH-1:0]                    wr_tag_i,
   input  logic                                                    flush_i,
   output icache_cfg_pkg::tag_entry_t [icache_cfg_pkg::NB_WAYS-1:0] rd_entry_o
);

   // Valid bits, kept apart so flush clears them in one cycle
   logic [icache_cfg_pkg::NB_WAYS-1:0][icache_cfg_pkg::NB_SETS-1:0] valid_q;

   // Tag array
   logic [icache_cfg_pkg::TAG_WIDTH-1:0] tag_mem
      [icache_cfg_pkg::NB_WAYS][icache_cfg_pkg::NB_SETS];

   // Valid bits: reset and flush clear all sets of all ways
   always_ff @(posedge clk)
   begin
      if (rst_i || flush_i)
      begin
         valid_q <= '0;
      end
      else if (wr_en_i)
      begin
         // Refill marks the written entry valid
         for (int w = 0; w < icache_cfg_pkg::NB_WAYS; w++)
         begin
            if (wr_way_i[w])
               valid_q[w][set_id_i] <= 1'b1;
         end
      end
   end

   // Tag write on refill, selected way only
   always_ff @(posedge clk)
   begin
      if (wr_en_i)
      begin
         for (int w = 0; w < icache_cfg_pkg::NB_WAYS; w++)
         begin
            if (wr_way_i[w])
               tag_mem[w][set_id_i] <= wr_tag_i;
         end
      end
   end

   // All ways of the set read in parallel
   // Result valid one cycle after rd_en_i
   always_ff @(posedge clk)
   begin
      if (rd_en_i)
      begin
         for (int w = 0; w < icache_cfg_pkg::NB_WAYS; w++)
         begin
            rd_entry_o[w].valid <= valid_q[w][set_id_i];
            rd_entry_o[w].tag   <= tag_mem[w][set_id_i];
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/pri_icache.sv */
////////////////////////////////////////
// Private instruction cache top level
// Controller, tag and data stores
// Refill request and response buffers
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pri_icache (
   input  logic                        clk,
   input  logic                        rst_i,
   // Core fetch port
   input  logic                        fetch_req_i,
   input  icache_cfg_pkg::fetch_addr_t fetch_addr_i,
   output logic                        fetch_gnt_o,
   output logic                        fetch_rvalid_o,
   output icache_bus_pkg::line_t       fetch_rdata_o,
   // Next memory level
   output logic                        refill_req_o,
   input  logic                        refill_gnt_i,
   output icache_bus_pkg::refill_req_t refill_addr_o,
   input  logic                        refill_r_valid_i,
   input  icache_bus_pkg::line_t       refill_r_data_i,
   // Mode control
   input  logic                        bypass_icache_i,
   output logic                        cache_is_bypassed_o,
   input  logic                        flush_icache_i,
   output logic                        cache_is_flushed_o
);

   // Controller to stores
   logic                                                     tag_rd_en;
   logic                                                     data_rd_en;
   logic [icache_cfg_pkg::SET_ID_WIDTH-1:0]                  set_id;
   logic                                                     wr_en;
   icache_cfg_pkg::way_sel_t                                 wr_way;
   logic [icache_cfg_pkg::TAG_WIDTH-1:0]                     wr_tag;
   icache_bus_pkg::line_t                                    wr_line;
   logic                                                     flush;
   icache_cfg_pkg::tag_entry_t [icache_cfg_pkg::NB_WAYS-1:0] tag_entry;
   icache_bus_pkg::line_t [icache_cfg_pkg::NB_WAYS-1:0]      way_line;

   // Controller to buffers
   logic                        refill_push;
   icache_bus_pkg::refill_req_t refill_push_addr;
   logic                        refill_ready;
   logic                        resp_valid;
   icache_bus_pkg::line_t       resp_line;

   ////////////////////////////////////////
   // Controller
   ////////////////////////////////////////

   icache_ctrl u_ctrl (
      .clk                 ( clk                 ),
      .rst_i               ( rst_i               ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .flush_icache_i      ( flush_icache_i      ),
      .cache_is_flushed_o  ( cache_is_flushed_o  ),
      .tag_rd_en_o         ( tag_rd_en           ),
      .data_rd_en_o        ( data_rd_en          ),
      .set_id_o            ( set_id              ),
      .wr_en_o             ( wr_en               ),
      .wr_way_o            ( wr_way              ),
      .wr_tag_o            ( wr_tag              ),
      .wr_line_o           ( wr_line             ),
      .flush_o             ( flush               ),
      .tag_entry_i         ( tag_entry           ),
      .line_i              ( way_line            ),
      .refill_push_o       ( refill_push         ),
      .refill_addr_o       ( refill_push_addr    ),
      .refill_ready_i      ( refill_ready        ),
      .resp_valid_i        ( resp_valid          ),
      .resp_line_i         ( resp_line           )
   );

   ////////////////////////////////////////
   // Stores, single port
   ////////////////////////////////////////

   icache_tag_ram u_tag_ram (
      .clk        ( clk        ),
      .rst_i      ( rst_i      ),
      .rd_en_i    ( tag_rd_en  ),
      .set_id_i   ( set_id     ),
      .wr_en_i    ( wr_en      ),
      .wr_way_i   ( wr_way     ),
      .wr_tag_i   ( wr_tag     ),
      .flush_i    ( flush      ),
      .rd_entry_o ( tag_entry  )
   );

   icache_data_ram u_data_ram (
      .clk       ( clk        ),
      .rd_en_i   ( data_rd_en ),
      .set_id_i  ( set_id     ),
      .wr_en_i   ( wr_en      ),
      .wr_way_i  ( wr_way     ),
      .wr_line_i ( wr_line    ),
      .rd_line_o ( way_line   )
   );

   ////////////////////////////////////////
   // Refill buffers
   ////////////////////////////////////////

   // Request buffer, popped by the memory grant
   icache_fifo #(
      .payload_t ( icache_bus_pkg::refill_req_t )
   ) u_req_fifo (
      .clk     ( clk              ),
      .rst_i   ( rst_i            ),
      .push_i  ( refill_push      ),
      .data_i  ( refill_push_addr ),
      .ready_o ( refill_ready     ),
      .valid_o ( refill_req_o     ),
      .data_o  ( refill_addr_o    ),
      .pop_i   ( refill_gnt_i     )
   );

   // Response buffer, always popped so memory is never stalled
   icache_fifo #(
      .payload_t ( icache_bus_pkg::line_t )
   ) u_resp_fifo (
      .clk     ( clk              ),
      .rst_i   ( rst_i            ),
      .push_i  ( refill_r_valid_i ),
      .data_i  ( refill_r_data_i  ),
      .ready_o (                  ),
      .valid_o ( resp_valid       ),
      .data_o  ( resp_line        ),
      .pop_i   ( 1'b1             )
   );

endmodule

`default_nettype wire

/* sources.f */
rtl/icache_cfg_pkg.sv
rtl/icache_bus_pkg.sv
rtl/icache_tag_ram.sv
rtl/icache_data_ram.sv
rtl/icache_fifo.sv
rtl/icache_ctrl.sv
rtl/pri_icache.sv
bench/tb_pri_icache.sv
